//--- rtl/mem_stage_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the memory-access stage of the MIPS pipeline
// Request, command, load tag and writeback structs plus access size
// Imported by every stage module and by the testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_stage_pkg;

  localparam int ADDR_W = 32;  // MIPS byte address width

  // Access width of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // At most one request per cycle from the execute stage
  typedef struct packed {
    logic              valid;
    logic              we;     // Store when set
    mem_size_e         size;
    logic              sign;   // Sign-extend on loads
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } mem_req_t;

  // Formatter to RAM with data already on its byte lanes
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-3:0] word_addr;
    logic [3:0]        byte_en;
    logic [31:0]       wdata;
  } mem_cmd_t;

  // Travels beside a load so the extractor can finish it
  typedef struct packed {
    logic      valid;
    mem_size_e size;
    logic      sign;
    logic [1:0] byte_off;
  } load_tag_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } wb_t;

endpackage

`default_nettype wire

//--- rtl/store_formatter.sv
//////////////////////////////////////////////////////////////////////
// Store formatter, first register of the memory stage
// Checks alignment, shifts store data onto byte lanes, builds byte
// enables and the load tag, all registered one cycle after accept
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module store_formatter (
  input  logic                     clk,
  input  logic                     rsta,
  input  logic                     step_en,   // Debug clock-control strobe
  input  mem_stage_pkg::mem_req_t  req,
  output mem_stage_pkg::mem_cmd_t  cmd,
  output mem_stage_pkg::load_tag_t tag,
  output logic                     addr_err   // One-cycle pulse on misalignment
);
  import mem_stage_pkg::*;

  logic [1:0]        byte_off;
  logic              misaligned;
  logic              go;          // Aligned and valid
  logic [3:0]        be_next;
  logic [31:0]       wdata_next;

  logic              wr_q;
  logic              rd_q;
  logic              tag_vld_q;
  logic              err_q;
  logic [ADDR_W-3:0] waddr_q;
  logic [3:0]        be_q;
  logic [31:0]       wdata_q;
  mem_size_e         size_q;
  logic              sign_q;
  logic [1:0]        off_q;

  assign byte_off = req.addr[1:0];

  // Size decode: enables and lane replication
  always_comb
  begin
    case (req.size)
      SIZE_BYTE:
      begin
        misaligned = 1'b0;
        be_next    = 4'b0001 << byte_off;
        wdata_next = {4{req.wdata[7:0]}};   // Same byte on all lanes
      end
      SIZE_HALF:
      begin
        misaligned = byte_off[0];            // Odd address
        be_next    = byte_off[1] ? 4'b1100 : 4'b0011;
        wdata_next = {2{req.wdata[15:0]}};
      end
      default:
      begin
        misaligned = |byte_off;              // Word must sit on 4-byte boundary
        be_next    = 4'b1111;
        wdata_next = req.wdata;
      end
    endcase
  end

  assign go = req.valid & ~misaligned;

  // Control bits
  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      tag_vld_q <= 1'b0;
      err_q     <= 1'b0;
    end
    else if (step_en)
    begin
      wr_q      <= go & req.we;
      rd_q      <= go & ~req.we;
      tag_vld_q <= go & ~req.we;    // Only loads produce writeback
      err_q     <= req.valid & misaligned;
    end
  end

  // Payload, qualified by the control bits downstream
  always_ff @(posedge clk)
  begin
    if (step_en)
    begin
      waddr_q <= req.addr[ADDR_W-1:2];
      be_q    <= be_next;
      wdata_q <= wdata_next;
      size_q  <= req.size;
      sign_q  <= req.sign;
      off_q   <= byte_off;
    end
  end

  assign cmd.wr        = wr_q;
  assign cmd.rd        = rd_q;
  assign cmd.word_addr = waddr_q;
  assign cmd.byte_en   = be_q;
  assign cmd.wdata     = wdata_q;

  assign tag.valid     = tag_vld_q;
  assign tag.size      = size_q;
  assign tag.sign      = sign_q;
  assign tag.byte_off  = off_q;

  assign addr_err      = err_q;

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
//////////////////////////////////////////////////////////////////////
// Single-port byte-writable data RAM in no-change mode
// Registered read, rdata holds through writes and idle cycles
// Also delays the load tag and gives the debug unit a word read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module data_mem #(
  parameter int DEPTH = 64                        // Words, power of two
) (
  input  logic                         clk,
  input  logic                         rsta,
  input  logic                         step_en,
  input  mem_stage_pkg::mem_cmd_t      cmd,
  input  mem_stage_pkg::load_tag_t     tag,
  output logic [31:0]                  rdata,
  output mem_stage_pkg::load_tag_t     tag_q,
  input  logic [$clog2(DEPTH)-1:0]     dbg_addr,  // Word address from debug unit
  output logic [31:0]                  dbg_data
);

  localparam int AW = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [31:0]   rd_q;
  logic [AW-1:0] idx;          // Word address wrapped to the array

  logic          tvld_q;
  logic [1:0]    tsize_q;
  logic          tsign_q;
  logic [1:0]    toff_q;

  // Zero contents at start, like the block RAM after configuration
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = 32'h0;
  end

  assign idx = cmd.word_addr[AW-1:0];

  // Per-byte write
  always_ff @(posedge clk)
  begin
    if (step_en && cmd.wr)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (cmd.byte_en[b])
          mem[idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
      end
    end
  end

  // Read port, no reset on the data
  always_ff @(posedge clk)
  begin
    if (step_en && cmd.rd)
      rd_q <= mem[idx];      // Untouched on writes, hence no-change
  end

  assign rdata = rd_q;

  // Tag stage lines up with the read
  always_ff @(posedge clk)
  begin
    if (rsta)
      tvld_q <= 1'b0;
    else if (step_en)
      tvld_q <= tag.valid;
  end

  always_ff @(posedge clk)
  begin
    if (step_en)
    begin
      tsize_q <= tag.size;
      tsign_q <= tag.sign;
      toff_q  <= tag.byte_off;
    end
  end

  assign tag_q.valid    = tvld_q;
  assign tag_q.size     = mem_stage_pkg::mem_size_e'(tsize_q);
  assign tag_q.sign     = tsign_q;
  assign tag_q.byte_off = toff_q;

  // Debug read sees a write right after its edge
  assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/load_extractor.sv
//////////////////////////////////////////////////////////////////////
// Load extractor, last register of the memory stage
// Picks the byte, halfword or word out of the read word, extends it
// and registers the writeback result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module load_extractor (
  input  logic                     clk,
  input  logic                     rsta,
  input  logic                     step_en,
  input  logic [31:0]              rdata,    // Word from RAM read register
  input  mem_stage_pkg::load_tag_t tag_q,
  output mem_stage_pkg::wb_t       wb
);
  import mem_stage_pkg::*;

  logic [31:0] shifted;
  logic [31:0] ext_data;
  logic        fill;         // Extension bit

  logic        vld_q;
  logic [31:0] data_q;

  // Addressed byte moved down to lane 0
  assign shifted = rdata >> {tag_q.byte_off, 3'b000};

  always_comb
  begin
    case (tag_q.size)
      SIZE_BYTE:
      begin
        fill     = tag_q.sign & shifted[7];
        ext_data = {{24{fill}}, shifted[7:0]};
      end
      SIZE_HALF:
      begin
        fill     = tag_q.sign & shifted[15];
        ext_data = {{16{fill}}, shifted[15:0]};
      end
      default:
      begin
        fill     = 1'b0;              // Word needs no extension
        ext_data = rdata;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rsta)
      vld_q <= 1'b0;
    else if (step_en)
      vld_q <= tag_q.valid;
  end

  // Data only moves when a load completes
  always_ff @(posedge clk)
  begin
    if (step_en && tag_q.valid)
      data_q <= ext_data;
  end

  assign wb.valid = vld_q;
  assign wb.data  = data_q;

endmodule

`default_nettype wire

//--- rtl/mem_stage_top.sv
//////////////////////////////////////////////////////////////////////
// Memory-access stage top level
// Formatter, data RAM and load extractor in a three-cycle pipeline
// Loads come back on wb three enabled cycles after accept
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_stage_top #(
  parameter int DEPTH = 64                     // RAM words, passed to data_mem
) (
  input  logic                     clk,
  input  logic                     rsta,
  input  logic                     step_en,    // Low freezes every register
  input  mem_stage_pkg::mem_req_t  req,
  input  logic [$clog2(DEPTH)-1:0] dbg_addr,
  output mem_stage_pkg::wb_t       wb,
  output logic                     addr_err,
  output logic [31:0]              dbg_data
);
  import mem_stage_pkg::*;

  mem_cmd_t    cmd;        // Formatter to RAM
  load_tag_t   tag;        // Load info, formatter stage
  load_tag_t   tag_q;      // Load info, RAM stage
  logic [31:0] rdata;

  // Alignment check, lane shift, byte enables
  store_formatter store_formatter_inst (
    .clk      (clk),
    .rsta     (rsta),
    .step_en  (step_en),
    .req      (req),
    .cmd      (cmd),
    .tag      (tag),
    .addr_err (addr_err)
  );

  data_mem #(
    .DEPTH (DEPTH)
  ) data_mem_inst (
    .clk      (clk),
    .rsta     (rsta),
    .step_en  (step_en),
    .cmd      (cmd),
    .tag      (tag),
    .rdata    (rdata),
    .tag_q    (tag_q),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  // Extension and writeback register
  load_extractor load_extractor_inst (
    .clk     (clk),
    .rsta    (rsta),
    .step_en (step_en),
    .rdata   (rdata),
    .tag_q   (tag_q),
    .wb      (wb)
  );

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// Free-running clock, reset held high for a set number of cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rsta
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rsta = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rsta <= 1'b0;           // Released on a rising edge like the stimulus
  end

endmodule

`default_nettype wire

//--- sim/tb_mem_stage.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the memory-access stage
// Loads and stores checked against a byte model by assertions
// Covers sizes, misalignment, step enable and the debug port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;
  import mem_stage_pkg::*;

  localparam int DEPTH     = 64;
  localparam int AW        = $clog2(DEPTH);
  localparam int NBYTES    = DEPTH * 4;
  localparam int BW        = $clog2(NBYTES);    // Byte index into the model
  localparam int PERIOD_NS = 100;
  localparam int RST_CYC   = 10;
  localparam int N_BURST   = 8;                 // Words per store/load burst
  localparam int N_RAND    = 400;               // Byte and half accesses
  localparam int N_MIS     = 24;
  localparam int N_ROUNDS  = 4;                 // Freeze rounds
  localparam int N_STEP    = 5;                 // Loads issued before each freeze

  // Worst-case cycles of each test
  localparam int T_RESET = RST_CYC + 6;
  localparam int T_WORD  = 3 * N_BURST + 10;
  localparam int T_SIZES = 2 * N_RAND + 10;
  localparam int T_MIS   = 3 * N_MIS + 10;
  localparam int T_STEP  = N_ROUNDS * (N_STEP + 8 + 10);
  localparam int T_DBG   = DEPTH + 10;
  localparam int WATCHDOG_NS =
    (T_RESET + T_WORD + T_SIZES + T_MIS + T_STEP + T_DBG + 100) * PERIOD_NS;

  typedef struct packed {
    logic [31:0] data;
    logic [31:0] due;                           // Enabled edge count when wb is seen
  } exp_t;

  logic          clk;
  logic          rsta;
  logic          step_en;
  mem_req_t      req;
  logic [AW-1:0] dbg_addr;
  logic          dbg_chk;                       // Compare dbg_data on this edge
  wb_t           wb;
  logic          addr_err;
  logic [31:0]   dbg_data;

  logic [7:0]    ref_mem [NBYTES];              // Byte model of the RAM
  exp_t          exp_q [$];
  logic [31:0]   en_cnt;                        // Enabled edges since reset
  logic [31:0]   err_due;
  logic [15:0]   lfsr;
  int            rst_edges = 0;
  int            n_pass = 0;
  int            n_fail = 0;

  clk_gen #(
    .PERIOD_NS  (PERIOD_NS),
    .RST_CYCLES (RST_CYC)
  ) clk_gen_inst (
    .clk  (clk),
    .rsta (rsta)
  );

  mem_stage_top #(
    .DEPTH (DEPTH)
  ) mem_stage_top_inst (
    .clk      (clk),
    .rsta     (rsta),
    .step_en  (step_en),
    .req      (req),
    .dbg_addr (dbg_addr),
    .wb       (wb),
    .addr_err (addr_err),
    .dbg_data (dbg_data)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};               // One step per bit
    end
    return r;
  endfunction

  function automatic int access_bytes(input mem_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // Half needs an even address, word a multiple of 4
  function automatic logic is_misaligned(input mem_size_e size, input logic [31:0] addr);
    case (size)
      SIZE_BYTE: return 1'b0;
      SIZE_HALF: return addr[0];
      default:   return addr[1:0] != 2'b00;
    endcase
  endfunction

  function automatic void model_store(input mem_req_t r);
    logic [BW-1:0] base;
    base = r.addr[BW-1:0];                     // Word address wraps at DEPTH
    for (int i = 0; i < access_bytes(r.size); i++)
      ref_mem[base + BW'(i)] = r.wdata[8*i +: 8];   // Little-endian lanes
  endfunction

  function automatic logic [31:0] model_load(input mem_req_t r);
    logic [BW-1:0] base;
    logic [31:0]   v;
    base = r.addr[BW-1:0];
    v    = '0;
    for (int i = 0; i < access_bytes(r.size); i++)
      v[8*i +: 8] = ref_mem[base + BW'(i)];
    if (r.size == SIZE_BYTE && r.sign && v[7])
      v[31:8] = '1;
    else if (r.size == SIZE_HALF && r.sign && v[15])
      v[31:16] = '1;
    return v;
  endfunction

  function automatic logic [31:0] model_word(input logic [AW-1:0] w);
    logic [31:0] v;
    for (int i = 0; i < 4; i++)
      v[8*i +: 8] = ref_mem[{w, 2'(i)}];
    return v;
  endfunction

  task automatic record_check(input logic ok, input string msg);
    assert (ok)
      n_pass++;
    else
    begin
      n_fail++;
      $display("Error %0t ns: %s", $time, msg);
    end
  endtask

  // Model and checks sample on the rising edge before outputs move
  always @(posedge clk)
  begin
    if (rsta)
    begin
      if (rst_edges != 0)                       // DUT outputs set by the first edge
        record_check(!wb.valid && !addr_err, "wb.valid or addr_err high in reset");
      rst_edges = rst_edges + 1;
      for (int i = 0; i < NBYTES; i++)
        ref_mem[i] = 8'h00;                     // RAM starts at zero
      exp_q.delete();
      en_cnt  = '0;
      err_due = '1;
    end
    else
    begin
      if (exp_q.size() != 0 && exp_q[0].due == en_cnt)
      begin
        record_check(wb.valid && wb.data == exp_q[0].data,
                     $sformatf("wb valid %0b data %08h, expected load data %08h",
                               wb.valid, wb.data, exp_q[0].data));
        if (step_en)
          void'(exp_q.pop_front());             // Held while frozen
      end
      else
        record_check(!wb.valid, "wb.valid high with no load due");
      record_check(addr_err == (err_due == en_cnt),
                   $sformatf("addr_err %0b, expected %0b", addr_err, err_due == en_cnt));
      if (dbg_chk)
        record_check(dbg_data == model_word(dbg_addr),
                     $sformatf("dbg_data %08h at word %0d, expected %08h",
                               dbg_data, dbg_addr, model_word(dbg_addr)));
      if (step_en)
      begin
        if (req.valid)                          // Accepted at this edge
        begin
          if (is_misaligned(req.size, req.addr))
            err_due = en_cnt + 1;
          else if (req.we)
            model_store(req);
          else
            exp_q.push_back('{data: model_load(req), due: en_cnt + 3});
        end
        en_cnt = en_cnt + 1;
      end
    end
  end

  task automatic send(input logic we, input mem_size_e size, input logic sign,
                      input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    req <= '{valid: 1'b1, we: we, size: size, sign: sign, addr: addr, wdata: wdata};
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      req <= '0;
    end
  endtask

  // Pipeline stalled for n edges
  task automatic freeze(input int n);
    repeat (n)
    begin
      @(posedge clk);
      req     <= '0;
      step_en <= 1'b0;
    end
    @(posedge clk);
    step_en <= 1'b1;
  endtask

  task automatic drain();
    idle(1);
    @(negedge clk);                             // Last accepted load is queued
    while (exp_q.size() != 0)
      @(negedge clk);
    idle(2);                                    // Last addr_err pulse gone too
  endtask

  task automatic report_test(input string name, input int fails_before);
    @(negedge clk);                             // Checks of the last edge are in
    if (n_fail == fails_before)
      $display("Test %s: passed", name);
    else
      $display("Test %s: failed, %0d bad checks", name, n_fail - fails_before);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns, stopping the run", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    int          fails;
    logic [31:0] addr;
    logic [31:0] burst_addr [N_BURST];
    mem_size_e   size;
    logic        we;
    logic        sign;

    req      = '0;
    step_en  = 1'b1;
    dbg_addr = '0;
    dbg_chk  = 1'b0;
    lfsr     = 16'd44;

    fails = n_fail;
    for (int i = 0; i < RST_CYC - 1; i++)      // Requests in reset must not run
    begin
      if (i % 2 == 0)
        send(1'b0, SIZE_WORD, 1'b0, rand_bits(32) & ~32'h3, 32'h0);
      else
        send(1'b0, SIZE_HALF, 1'b0, rand_bits(32) | 32'h1, 32'h0);   // Misaligned
    end
    idle(5);                                    // Last reset edge sees req cleared
    report_test("reset_state", fails);

    fails = n_fail;
    for (int i = 0; i < N_BURST; i++)
    begin
      burst_addr[i] = rand_bits(32) & ~32'h3;
      send(1'b1, SIZE_WORD, 1'b0, burst_addr[i], rand_bits(32));
    end
    for (int i = N_BURST - 1; i >= 0; i--)     // First load hits the last store
      send(1'b0, SIZE_WORD, 1'b0, burst_addr[i], 32'h0);
    drain();
    report_test("word_store_load", fails);

    fails = n_fail;
    for (int i = 0; i < N_RAND; i++)
    begin
      size = (rand_bits(1) != 0) ? SIZE_HALF : SIZE_BYTE;
      we   = rand_bits(1) != 0;
      sign = rand_bits(1) != 0;
      addr = rand_bits(32);
      if (size == SIZE_HALF)
        addr[0] = 1'b0;
      send(we, size, sign, addr, rand_bits(32));
      if (rand_bits(2) == 0)
        idle(1);                                // Occasional bubble
    end
    drain();
    report_test("byte_half_sizes", fails);

    fails = n_fail;
    for (int i = 0; i < N_MIS; i++)
    begin
      addr = rand_bits(32);
      if (rand_bits(1) != 0)
      begin
        size    = SIZE_HALF;
        addr[0] = 1'b1;
      end
      else
      begin
        size = SIZE_WORD;
        if (addr[1:0] == 2'b00)
          addr[1:0] = 2'b10;
      end
      send(rand_bits(1) != 0, size, 1'b0, addr, rand_bits(32));
      send(1'b0, SIZE_WORD, 1'b0, addr & ~32'h3, 32'h0);   // Word must be unchanged
    end
    drain();
    report_test("misaligned", fails);

    fails = n_fail;
    for (int r = 0; r < N_ROUNDS; r++)
    begin
      for (int i = 0; i < N_STEP; i++)
      begin
        addr = rand_bits(32);
        if (i % 2 == 0)
          send(1'b0, SIZE_WORD, 1'b0, addr & ~32'h3, 32'h0);
        else
          send(1'b0, SIZE_BYTE, 1'b1, addr, 32'h0);
      end
      freeze(1 + rand_bits(3));                 // Loads still in flight
      drain();
    end
    report_test("step_enable", fails);

    fails = n_fail;
    for (int w = 0; w < DEPTH; w++)
    begin
      @(posedge clk);
      dbg_addr <= AW'(w);
      dbg_chk  <= 1'b1;
    end
    @(posedge clk);
    dbg_chk <= 1'b0;
    report_test("debug_read", fails);

    idle(2);
    @(negedge clk);
    $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
rtl/mem_stage_pkg.sv
rtl/store_formatter.sv
rtl/data_mem.sv
rtl/load_extractor.sv
rtl/mem_stage_top.sv
sim/clk_gen.sv
sim/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory-stage testbench with Verilator and runs it
# Pass or fail comes from the last lines of sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_mem_stage \
  -f all.f \
  -o tb_mem_stage \
  && ./obj_dir/tb_mem_stage | tee sim.log \
  && grep -qx "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
